// ==== src/fetch_settings.svh ====
// Fetch stage build settings
// Datapath width, BTB geometry, aligner queue depth and reset PC
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Address and data width
`define FETCH_XLEN 32

// BTB geometry, entries must equal 2**index bits
`define FETCH_BTB_IDX_BITS 3
`define FETCH_BTB_ENTRIES 8

// Aligner queue capacity in 16-bit parcels
`define FETCH_QUEUE_HALVES 4

// First instruction address after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

// ==== src/fetch_pkg.sv ====
// Fetch stage shared types
// Vector typedefs for addresses, memory words, parcels and BTB fields
`include "fetch_settings.svh"

package fetch_pkg;

  // Byte address
  typedef logic [`FETCH_XLEN-1:0] addr_t;

  // One aligned memory word
  typedef logic [31:0] word_t;

  // One 16-bit instruction parcel
  typedef logic [15:0] halfword_t;

  // Issued instruction, compressed ones sit in the low half
  typedef logic [31:0] instr_t;

  // BTB index, taken from PC bits starting at bit 1
  typedef logic [`FETCH_BTB_IDX_BITS-1:0] btb_idx_t;

  // BTB tag, all PC bits above the index
  typedef logic [`FETCH_XLEN-`FETCH_BTB_IDX_BITS-2:0] btb_tag_t;

endpackage : fetch_pkg

// ==== src/fetch_req_if.sv ====
// Request bus between the PC controller and the parcel aligner
// Response qualifiers and flush go forward, ready and issue come back
interface fetch_req_if;

  // Aligner to controller
  logic             req_ready;
  logic             issue;

  // Controller to aligner
  logic             resp_valid;
  fetch_pkg::addr_t resp_addr;
  logic             start_upper;
  logic             flush;

  modport ctrl (
    input  req_ready, issue,
    output resp_valid, resp_addr, start_upper, flush
  );

  modport align (
    input  resp_valid, resp_addr, start_upper, flush,
    output req_ready, issue
  );

endinterface : fetch_req_if

// ==== src/fetch_pc_ctrl.sv ====
// Fetch PC controller
// Word address register, next address select and in-flight response tracking
`include "fetch_settings.svh"

module fetch_pc_ctrl (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_redirect,
  input  fetch_pkg::addr_t i_redirect_pc,
  input  logic             i_pred_hit,
  input  fetch_pkg::addr_t i_pred_target,
  fetch_req_if.ctrl        bus,
  output fetch_pkg::addr_t o_fetch_addr
);

  localparam fetch_pkg::addr_t reset_pc = `FETCH_RESET_PC;

  fetch_pkg::addr_t fetch_addr_q;
  fetch_pkg::addr_t resp_addr_q;
  fetch_pkg::addr_t target;
  logic             pend_upper_q;
  logic             resp_valid_q;
  logic             start_upper_q;
  logic             pred_taken;
  logic             req;

  // Prediction only counts once the instruction actually leaves the stage
  assign pred_taken = bus.issue & i_pred_hit;
  assign bus.flush  = i_redirect | pred_taken;
  // Execute wins over the BTB
  assign target     = i_redirect ? i_redirect_pc : i_pred_target;
  // No request in a flush cycle, the address is about to change
  assign req        = bus.req_ready & ~bus.flush;

  // ====================
  // Fetch address
  // ====================
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      fetch_addr_q  <= {reset_pc[`FETCH_XLEN-1:2], 2'b00};
      pend_upper_q  <= reset_pc[1];
      resp_valid_q  <= 1'b0;
      start_upper_q <= 1'b0;
    end else begin
      // Response arrives one cycle after the request
      resp_valid_q  <= req;
      start_upper_q <= req & pend_upper_q;
      if (bus.flush) begin
        fetch_addr_q <= {target[`FETCH_XLEN-1:2], 2'b00};
        // Odd halfword target, drop the low parcel of the first word
        pend_upper_q <= target[1];
      end else if (req) begin
        fetch_addr_q <= fetch_addr_q + fetch_pkg::addr_t'(4);
        pend_upper_q <= 1'b0;
      end
    end
  end

  // Address of the word in flight
  always_ff @(posedge i_clk) begin
    resp_addr_q <= fetch_addr_q;
  end

  assign bus.resp_valid  = resp_valid_q;
  assign bus.resp_addr   = resp_addr_q;
  assign bus.start_upper = start_upper_q;
  assign o_fetch_addr    = fetch_addr_q;

endmodule : fetch_pc_ctrl

// ==== src/branch_target_buffer.sv ====
// Direct-mapped branch target buffer
// Combinational lookup on the issued PC, written by execute
`include "fetch_settings.svh"

module branch_target_buffer (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  fetch_pkg::addr_t i_lookup_pc,
  input  logic             i_update,
  input  fetch_pkg::addr_t i_update_pc,
  input  fetch_pkg::addr_t i_update_target,
  input  logic             i_update_taken,
  output logic             o_hit,
  output fetch_pkg::addr_t o_target
);

  logic [`FETCH_BTB_ENTRIES-1:0] valid_q;
  fetch_pkg::btb_tag_t           tag_q [`FETCH_BTB_ENTRIES];
  fetch_pkg::addr_t              target_q [`FETCH_BTB_ENTRIES];

  fetch_pkg::btb_idx_t lookup_idx;
  fetch_pkg::btb_tag_t lookup_tag;
  fetch_pkg::btb_idx_t update_idx;
  fetch_pkg::btb_tag_t update_tag;

  // Bit 0 is always zero for an instruction address
  assign lookup_idx = i_lookup_pc[`FETCH_BTB_IDX_BITS:1];
  assign lookup_tag = i_lookup_pc[`FETCH_XLEN-1:`FETCH_BTB_IDX_BITS+1];
  assign update_idx = i_update_pc[`FETCH_BTB_IDX_BITS:1];
  assign update_tag = i_update_pc[`FETCH_XLEN-1:`FETCH_BTB_IDX_BITS+1];

  // ====================
  // Entry state
  // ====================
  // Not-taken update invalidates the entry
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      valid_q <= '0;
    end else if (i_update) begin
      valid_q[update_idx] <= i_update_taken;
    end
  end

  // Tag and target only matter while the entry is valid
  always_ff @(posedge i_clk) begin
    if (i_update && i_update_taken) begin
      tag_q[update_idx]    <= update_tag;
      target_q[update_idx] <= i_update_target;
    end
  end

  // Lookup
  assign o_hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign o_target = target_q[lookup_idx];

endmodule : branch_target_buffer

// ==== src/parcel_aligner.sv ====
// Parcel aligner
// Queues returned halfwords and issues one 16-bit or 32-bit instruction per cycle
`include "fetch_settings.svh"

module parcel_aligner (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  fetch_pkg::word_t  i_fetch_data,
  input  logic              i_stall,
  fetch_req_if.align        bus,
  output logic              o_instr_valid,
  output fetch_pkg::instr_t o_instr,
  output fetch_pkg::addr_t  o_instr_pc,
  output logic              o_is_compressed
);

  // Queue plus the two parcels of an arriving word
  localparam int view_n = `FETCH_QUEUE_HALVES + 2;
  localparam int cnt_w  = $clog2(view_n + 1);

  typedef logic [cnt_w-1:0] cnt_t;

  // Queue state
  fetch_pkg::halfword_t q_h [`FETCH_QUEUE_HALVES];
  cnt_t                 cnt_q;
  fetch_pkg::addr_t     head_pc_q;

  // Combined view of queued and arriving parcels
  fetch_pkg::halfword_t view_h [view_n];
  fetch_pkg::halfword_t in_h0;
  fetch_pkg::halfword_t in_h1;
  cnt_t                 in_n;
  cnt_t                 total;
  cnt_t                 used;
  cnt_t                 cnt_next;
  fetch_pkg::addr_t     head_pc;
  logic                 is_comp;

  // ====================
  // Incoming word
  // ====================
  // Only the upper parcel is kept after a jump to an odd halfword
  assign in_h0 = bus.start_upper ? i_fetch_data[31:16] : i_fetch_data[15:0];
  assign in_h1 = i_fetch_data[31:16];
  assign in_n  = !bus.resp_valid ? cnt_t'(0) :
                 bus.start_upper ? cnt_t'(1) : cnt_t'(2);
  assign total = cnt_q + in_n;

  // Arriving parcels line up right behind the queued ones
  for (genvar g = 0; g < view_n; g++) begin : g_view
    if (g < `FETCH_QUEUE_HALVES) begin : g_queued
      assign view_h[g] = (cnt_t'(g) < cnt_q)  ? q_h[g] :
                         (cnt_t'(g) == cnt_q) ? in_h0 : in_h1;
    end else begin : g_extra
      assign view_h[g] = (cnt_t'(g) == cnt_q) ? in_h0 : in_h1;
    end
  end

  // Empty queue, head PC comes straight from the response
  assign head_pc = (cnt_q != '0) ? head_pc_q :
                   {bus.resp_addr[`FETCH_XLEN-1:2], bus.start_upper, 1'b0};

  // ====================
  // Issue
  // ====================
  // Low bits 11 mark a 32-bit instruction
  assign is_comp       = (view_h[0][1:0] != 2'b11);
  // Spanning instruction waits until its second parcel shows up
  assign o_instr_valid = (total >= (is_comp ? cnt_t'(1) : cnt_t'(2)));
  assign o_instr       = is_comp ? {16'h0000, view_h[0]} : {view_h[1], view_h[0]};
  assign o_instr_pc    = head_pc;
  assign o_is_compressed = is_comp;

  // Stall holds the head, so outputs stay put
  assign bus.issue = o_instr_valid & ~i_stall;
  assign used      = !bus.issue ? cnt_t'(0) :
                     is_comp    ? cnt_t'(1) : cnt_t'(2);
  assign cnt_next  = total - used;

  // Leave room for a full word arriving on top of the projected fill
  assign bus.req_ready = (cnt_next <= cnt_t'(`FETCH_QUEUE_HALVES - 2));

  // ====================
  // Queue update
  // ====================
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      cnt_q <= '0;
    end else if (bus.flush) begin
      // Redirect drops everything, including a word arriving now
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_next;
    end
  end

  // Shift out consumed parcels, pull in new ones
  always_ff @(posedge i_clk) begin
    head_pc_q <= head_pc + fetch_pkg::addr_t'({used, 1'b0});
    for (int j = 0; j < `FETCH_QUEUE_HALVES; j++) begin
      q_h[j] <= view_h[j + int'(used)];
    end
  end

endmodule : parcel_aligner

// ==== src/fetch_stage.sv ====
// Instruction fetch stage top
// PC controller, parcel aligner and BTB joined on plain memory and pipeline ports
module fetch_stage (
  input  logic              i_clk,
  input  logic              i_rst_n,
  // Instruction memory, one cycle read latency
  output fetch_pkg::addr_t  o_fetch_addr,
  input  fetch_pkg::word_t  i_fetch_data,
  // Execute redirect
  input  logic              i_redirect,
  input  fetch_pkg::addr_t  i_redirect_pc,
  // BTB update from execute
  input  logic              i_btb_update,
  input  fetch_pkg::addr_t  i_btb_update_pc,
  input  fetch_pkg::addr_t  i_btb_update_target,
  input  logic              i_btb_update_taken,
  // Downstream back-pressure
  input  logic              i_stall,
  // Issued instruction
  output logic              o_instr_valid,
  output fetch_pkg::instr_t o_instr,
  output fetch_pkg::addr_t  o_instr_pc,
  output logic              o_is_compressed,
  output logic              o_pred_taken,
  output fetch_pkg::addr_t  o_pred_target
);

  logic             btb_hit;
  fetch_pkg::addr_t btb_target;

  fetch_req_if req_bus ();

  fetch_pc_ctrl u_pc_ctrl (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .i_pred_hit    (btb_hit),
    .i_pred_target (btb_target),
    .bus           (req_bus.ctrl),
    .o_fetch_addr  (o_fetch_addr)
  );

  parcel_aligner u_aligner (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_fetch_data    (i_fetch_data),
    .i_stall         (i_stall),
    .bus             (req_bus.align),
    .o_instr_valid   (o_instr_valid),
    .o_instr         (o_instr),
    .o_instr_pc      (o_instr_pc),
    .o_is_compressed (o_is_compressed)
  );

  // Looked up with the PC of the instruction at the head
  branch_target_buffer u_btb (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_lookup_pc     (o_instr_pc),
    .i_update        (i_btb_update),
    .i_update_pc     (i_btb_update_pc),
    .i_update_target (i_btb_update_target),
    .i_update_taken  (i_btb_update_taken),
    .o_hit           (btb_hit),
    .o_target        (btb_target)
  );

  // Prediction only means something for a valid instruction
  assign o_pred_taken  = btb_hit & o_instr_valid;
  assign o_pred_target = btb_target;

endmodule : fetch_stage

// ==== dv/fetch_checker.sv ====
// Fetch stage checker
// Mirrors the BTB and checks every issued instruction against memory and PC order
`include "fetch_settings.svh"

module fetch_checker (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_redirect,
  input  fetch_pkg::addr_t  i_redirect_pc,
  input  logic              i_btb_update,
  input  fetch_pkg::addr_t  i_btb_update_pc,
  input  fetch_pkg::addr_t  i_btb_update_target,
  input  logic              i_btb_update_taken,
  input  logic              i_stall,
  input  logic              i_instr_valid,
  input  fetch_pkg::instr_t i_instr,
  input  fetch_pkg::addr_t  i_instr_pc,
  input  logic              i_is_compressed,
  input  logic              i_pred_taken,
  input  fetch_pkg::addr_t  i_pred_target,
  output int                o_errors,
  output int                o_checks
);

  // BTB mirror
  logic                 mir_valid [`FETCH_BTB_ENTRIES];
  fetch_pkg::btb_tag_t  mir_tag [`FETCH_BTB_ENTRIES];
  fetch_pkg::addr_t     mir_target [`FETCH_BTB_ENTRIES];

  fetch_pkg::addr_t  exp_pc;
  logic              held;
  fetch_pkg::instr_t held_instr;
  fetch_pkg::addr_t  held_pc;

  // Memory model is 64 words, address bits 7:2 select the word
  function automatic fetch_pkg::halfword_t mem_half(fetch_pkg::addr_t a);
    fetch_pkg::word_t w;
    w = tb_fetch_stage.mem[a[7:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic flag_error(string msg);
    o_errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  initial begin
    o_errors = 0;
    o_checks = 0;
  end

  always @(posedge i_clk) begin
    fetch_pkg::halfword_t h0;
    fetch_pkg::halfword_t h1;
    fetch_pkg::instr_t    exp_instr;
    fetch_pkg::btb_idx_t  idx;
    logic                 comp;
    logic                 hit;
    if (!i_rst_n) begin
      exp_pc <= `FETCH_RESET_PC;
      held   <= 1'b0;
      for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) mir_valid[i] <= 1'b0;
    end else begin
      // Stalled head must not move
      if (held && (!i_instr_valid || i_instr != held_instr || i_instr_pc != held_pc))
        flag_error($sformatf("stalled output changed, pc %h -> %h", held_pc, i_instr_pc));
      if (i_instr_valid && !i_stall) begin
        o_checks++;
        h0 = mem_half(i_instr_pc);
        h1 = mem_half(i_instr_pc + 2);
        comp = (h0[1:0] != 2'b11);
        exp_instr = comp ? {16'h0000, h0} : {h1, h0};
        if (i_instr_pc != exp_pc)
          flag_error($sformatf("pc %h, expected %h", i_instr_pc, exp_pc));
        if (i_instr != exp_instr || i_is_compressed != comp)
          flag_error($sformatf("instr %h at pc %h, expected %h", i_instr, i_instr_pc,
                               exp_instr));
        idx = i_instr_pc[`FETCH_BTB_IDX_BITS:1];
        hit = mir_valid[idx] &&
              mir_tag[idx] == i_instr_pc[`FETCH_XLEN-1:`FETCH_BTB_IDX_BITS+1];
        if (i_pred_taken != hit)
          flag_error($sformatf("pred_taken %b at pc %h, expected %b", i_pred_taken,
                               i_instr_pc, hit));
        else if (hit && i_pred_target != mir_target[idx])
          flag_error($sformatf("pred_target %h, expected %h", i_pred_target,
                               mir_target[idx]));
        // Predicted target or the next sequential parcel
        exp_pc <= hit ? mir_target[idx] : i_instr_pc + (comp ? 2 : 4);
      end
      // Execute redirect overrides any prediction
      if (i_redirect) exp_pc <= i_redirect_pc;
      held       <= i_instr_valid && i_stall && !i_redirect;
      held_instr <= i_instr;
      held_pc    <= i_instr_pc;
      if (i_btb_update) begin
        idx = i_btb_update_pc[`FETCH_BTB_IDX_BITS:1];
        mir_valid[idx]  <= i_btb_update_taken;
        mir_tag[idx]    <= i_btb_update_pc[`FETCH_XLEN-1:`FETCH_BTB_IDX_BITS+1];
        mir_target[idx] <= i_btb_update_target;
      end
    end
  end

endmodule : fetch_checker

// ==== dv/fetch_asserts.sv ====
// Fetch stage assertions
// Flush, stall hold and fetch address alignment
module fetch_asserts (
  input logic              i_clk,
  input logic              i_rst_n,
  input logic              i_flush,
  input logic              i_resp_valid,
  input logic              i_redirect,
  input logic              i_stall,
  input logic              i_instr_valid,
  input fetch_pkg::instr_t i_instr,
  input fetch_pkg::addr_t  i_fetch_addr
);

  // No response survives a redirect
  a_flush_kills_resp : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_flush |=> !i_resp_valid) else $error("response valid after flush");

  // Held instruction stays put under back-pressure
  a_stall_hold : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_instr_valid && i_stall && !i_redirect) |=> (i_instr_valid && $stable(i_instr)))
    else $error("instruction changed while stalled");

  // Memory is only ever asked for whole words
  a_addr_aligned : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_fetch_addr[1:0] == 2'b00) else $error("unaligned fetch address");

endmodule : fetch_asserts

bind fetch_stage fetch_asserts u_asserts (
  .i_clk         (i_clk),
  .i_rst_n       (i_rst_n),
  .i_flush       (req_bus.flush),
  .i_resp_valid  (req_bus.resp_valid),
  .i_redirect    (i_redirect),
  .i_stall       (i_stall),
  .i_instr_valid (o_instr_valid),
  .i_instr       (o_instr),
  .i_fetch_addr  (o_fetch_addr)
);

// ==== dv/tb_fetch_stage.sv ====
// Fetch stage testbench
// Clock, reset, memory model and a scenario table of redirects, BTB updates and stalls
`include "fetch_settings.svh"

module tb_fetch_stage;

  typedef struct packed {
    logic             redir;
    fetch_pkg::addr_t pc;
    logic             upd;
    fetch_pkg::addr_t upd_pc;
    fetch_pkg::addr_t upd_target;
    logic             upd_taken;
    logic [7:0]       stall_pct;
    logic [15:0]      cycles;
  } row_t;

  localparam int n_rows = 8;

  logic i_clk;
  logic i_rst_n;
  logic i_redirect;
  logic i_btb_update;
  logic i_btb_update_taken;
  logic i_stall;
  logic o_instr_valid;
  logic o_is_compressed;
  logic o_pred_taken;
  fetch_pkg::addr_t  o_fetch_addr;
  fetch_pkg::addr_t  i_redirect_pc;
  fetch_pkg::addr_t  i_btb_update_pc;
  fetch_pkg::addr_t  i_btb_update_target;
  fetch_pkg::addr_t  o_instr_pc;
  fetch_pkg::addr_t  o_pred_target;
  fetch_pkg::word_t  i_fetch_data;
  fetch_pkg::instr_t o_instr;
  fetch_pkg::word_t  mem [64];
  row_t              rows [n_rows];
  int                errors;
  int                checks;
  int                timeouts;

  fetch_stage DUT (.*);

  fetch_checker u_checker (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_redirect (i_redirect),
    .i_redirect_pc (i_redirect_pc), .i_btb_update (i_btb_update),
    .i_btb_update_pc (i_btb_update_pc), .i_btb_update_target (i_btb_update_target),
    .i_btb_update_taken (i_btb_update_taken), .i_stall (i_stall),
    .i_instr_valid (o_instr_valid), .i_instr (o_instr), .i_instr_pc (o_instr_pc),
    .i_is_compressed (o_is_compressed), .i_pred_taken (o_pred_taken),
    .i_pred_target (o_pred_target), .o_errors (errors), .o_checks (checks)
  );

  always #5 i_clk = ~i_clk;

  // One cycle read latency
  always @(posedge i_clk) i_fetch_data <= mem[o_fetch_addr[7:2]];

  // ====================
  // Program image
  // ====================
  // Random parcels with about half of them opening a 32-bit instruction
  task automatic fill_program();
    logic [31:0] r;
    fetch_pkg::halfword_t h;
    for (int i = 0; i < 128; i++) begin
      r = $urandom;
      h = r[15:0];
      if (r[31]) h[1:0] = 2'b11;
      else if (h[1:0] == 2'b11) h[1:0] = 2'b01;
      if (i[0]) mem[i >> 1][31:16] = h;
      else mem[i >> 1][15:0] = h;
    end
  endtask

  task automatic wait_issue(int row);
    int n;
    n = 0;
    // First sample lands after the flush has emptied the queue
    do begin
      @(posedge i_clk);
      n++;
    end while (!o_instr_valid && n < 20);
    if (!o_instr_valid) begin
      timeouts++;
      $display("Timeout: nothing issued within 20 cycles in scenario row %0d", row);
    end
  endtask

  initial begin
    process_rows();
  end

  task automatic process_rows();
    void'($urandom(32'h7c226ffd));
    i_clk = 0;
    i_rst_n = 0;
    i_redirect = 0;
    i_redirect_pc = '0;
    i_btb_update = 0;
    i_btb_update_pc = '0;
    i_btb_update_target = '0;
    i_btb_update_taken = 0;
    i_stall = 0;
    i_fetch_data = '0;
    timeouts = 0;
    fill_program();
    // redir, pc, upd, upd_pc, upd_target, taken, stall %, cycles
    rows[0] = '{1'b0, 32'h00, 1'b0, 32'h00, 32'h00, 1'b0, 8'd0,  16'd40};
    rows[1] = '{1'b1, 32'h40, 1'b0, 32'h00, 32'h00, 1'b0, 8'd30, 16'd60};
    rows[2] = '{1'b1, 32'h1a, 1'b0, 32'h00, 32'h00, 1'b0, 8'd30, 16'd60};
    rows[3] = '{1'b1, 32'h20, 1'b1, 32'h20, 32'h10, 1'b1, 8'd0,  16'd40};
    rows[4] = '{1'b1, 32'h20, 1'b1, 32'h20, 32'h10, 1'b0, 8'd20, 16'd40};
    rows[5] = '{1'b1, 32'h36, 1'b1, 32'h36, 32'h36, 1'b1, 8'd40, 16'd30};
    rows[6] = '{1'b1, 32'h06, 1'b1, 32'h36, 32'h00, 1'b0, 8'd50, 16'd60};
    rows[7] = '{1'b1, 32'h7e, 1'b0, 32'h00, 32'h00, 1'b0, 8'd0,  16'd40};
    repeat (10) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      @(posedge i_clk);
      i_btb_update        <= rows[r].upd;
      i_btb_update_pc     <= rows[r].upd_pc;
      i_btb_update_target <= rows[r].upd_target;
      i_btb_update_taken  <= rows[r].upd_taken;
      @(posedge i_clk);
      i_btb_update <= 1'b0;
      i_redirect    <= rows[r].redir;
      i_redirect_pc <= rows[r].pc;
      @(posedge i_clk);
      i_redirect <= 1'b0;
      wait_issue(r);
      for (int c = 0; c < rows[r].cycles; c++) begin
        @(posedge i_clk);
        i_stall <= ($urandom % 100) < rows[r].stall_pct;
      end
      @(posedge i_clk);
      i_stall <= 1'b0;
    end
    repeat (5) @(posedge i_clk);
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

endmodule : tb_fetch_stage

// ==== vlog.f ====
+incdir+src
src/fetch_pkg.sv
src/fetch_req_if.sv
src/fetch_pc_ctrl.sv
src/branch_target_buffer.sv
src/parcel_aligner.sv
src/fetch_stage.sv
dv/fetch_checker.sv
dv/fetch_asserts.sv
dv/tb_fetch_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_fetch_stage --Mdir obj_dir -o sim_fetch

out="$(./obj_dir/sim_fetch)"
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
